// ==== design/shell_pkg.sv ====
/*
 * Shared widths, response codes and FSM encodings for the pcis host master.
 * RTL and testbench refer to these through shell_pkg:: scoped names.
 */

package shell_pkg;

   // ----------------------------------------
   // bus widths
   // ----------------------------------------
   typedef logic [63:0]  addr_t;
   typedef logic [31:0]  word_t;
   typedef logic [511:0] beat_t;
   typedef logic [63:0]  strb_t;
   typedef logic [5:0]   axi_id_t;
   typedef logic [1:0]   resp_t;

   // word lane select inside a 64-byte beat
   localparam int LANE_LSB = 2;
   localparam int LANE_MSB = 5;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // ----------------------------------------
   // engine states
   // ----------------------------------------
   typedef enum logic [1:0] {W_IDLE, W_ADDR_DATA, W_RESP} wr_state_t;
   typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA, R_RESP} rd_state_t;

endpackage

// ==== design/shell_if.sv ====
/*
 * Internal valid/ready links of the pcis master.
 * host_req_if carries a dispatched request, host_rsp_if an engine response.
 */

`timescale 1ns/1ps

interface host_req_if;
   logic              valid;
   logic              ready;
   shell_pkg::addr_t  addr;
   shell_pkg::word_t  wdata;
   shell_pkg::axi_id_t id;

   modport src (
      output valid, addr, wdata, id,
      input  ready
   );

   modport dst (
      input  valid, addr, wdata, id,
      output ready
   );
endinterface

interface host_rsp_if;
   logic               valid;
   logic               ready;
   shell_pkg::axi_id_t id;
   shell_pkg::word_t   rdata;
   shell_pkg::resp_t   resp;

   modport src (
      output valid, id, rdata, resp,
      input  ready
   );

   modport dst (
      input  valid, id, rdata, resp,
      output ready
   );
endinterface

// ==== design/host_req_fifo.sv ====
/*
 * Host request queue. Dispatches the head in order to the write or read engine,
 * holds a read that hits the line of a still busy write, and flushes on FLR.
 */

`timescale 1ns/1ps

module host_req_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic               clk_out,
   input  logic               sync_rst_n,
   input  logic               flr_i,
   input  logic               req_valid_i,
   input  logic               req_write_i,
   input  shell_pkg::addr_t   req_addr_i,
   input  shell_pkg::word_t   req_wdata_i,
   input  shell_pkg::axi_id_t req_id_i,
   output logic               req_ready_o,
   host_req_if.src            wr_req,
   host_req_if.src            rd_req
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   shell_pkg::addr_t   addr_mem [FIFO_DEPTH];
   shell_pkg::word_t   data_mem [FIFO_DEPTH];
   shell_pkg::axi_id_t id_mem   [FIFO_DEPTH];
   logic               wr_mem   [FIFO_DEPTH];

   logic [PTR_W:0] wr_ptr_q;
   logic [PTR_W:0] rd_ptr_q;
   logic [PTR_W:0] count;
   logic [63:shell_pkg::LANE_MSB+1] last_wr_line_q;
   logic           empty;
   logic           head_write;
   logic           raw_hold;
   logic           push;
   logic           pop;

   assign count       = wr_ptr_q - rd_ptr_q;
   assign empty       = (count == '0);
   assign req_ready_o = (count != (PTR_W+1)'(FIFO_DEPTH)) && !flr_i;
   assign push        = req_valid_i && req_ready_o;

   // ----------------------------------------
   // head dispatch
   // ----------------------------------------
   assign head_write = wr_mem[rd_ptr_q[PTR_W-1:0]];
   // read to the line of the last write waits until the write engine is idle
   assign raw_hold   = (addr_mem[rd_ptr_q[PTR_W-1:0]][63:shell_pkg::LANE_MSB+1] == last_wr_line_q)
                       && !wr_req.ready;

   assign wr_req.valid = !empty && head_write;
   assign rd_req.valid = !empty && !head_write && !raw_hold;
   assign wr_req.addr  = addr_mem[rd_ptr_q[PTR_W-1:0]];
   assign rd_req.addr  = addr_mem[rd_ptr_q[PTR_W-1:0]];
   assign wr_req.wdata = data_mem[rd_ptr_q[PTR_W-1:0]];
   assign rd_req.wdata = data_mem[rd_ptr_q[PTR_W-1:0]];
   assign wr_req.id    = id_mem[rd_ptr_q[PTR_W-1:0]];
   assign rd_req.id    = id_mem[rd_ptr_q[PTR_W-1:0]];

   assign pop = (wr_req.valid && wr_req.ready) || (rd_req.valid && rd_req.ready);

   always_ff @(posedge clk_out) begin
      if (push) begin
         addr_mem[wr_ptr_q[PTR_W-1:0]] <= req_addr_i;
         data_mem[wr_ptr_q[PTR_W-1:0]] <= req_wdata_i;
         id_mem[wr_ptr_q[PTR_W-1:0]]   <= req_id_i;
         wr_mem[wr_ptr_q[PTR_W-1:0]]   <= req_write_i;
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr_q       <= '0;
         rd_ptr_q       <= '0;
         last_wr_line_q <= '0;
      end else begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         // flr drops everything not yet handed to an engine
         if (flr_i)
            rd_ptr_q <= wr_ptr_q;
         else if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_req.valid && wr_req.ready)
            last_wr_line_q <= wr_req.addr[63:shell_pkg::LANE_MSB+1];
      end
   end

   a_word_aligned: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      push |-> (req_addr_i[1:0] == 2'b00));

   a_count_bound: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      count <= (PTR_W+1)'(FIFO_DEPTH));

endmodule

// ==== design/pcis_write_master.sv ====
/*
 * Single-beat AXI4 write engine on pcis. Takes one poke, places the word in
 * its lane of the 512-bit beat, and returns bid/bresp as the host response.
 */

`timescale 1ns/1ps

module pcis_write_master (
   input  logic                clk_out,
   input  logic                sync_rst_n,
   host_req_if.dst             req,
   host_rsp_if.src             rsp,
   output logic                pcis_awvalid_o,
   input  logic                pcis_awready_i,
   output shell_pkg::addr_t    pcis_awaddr_o,
   output shell_pkg::axi_id_t  pcis_awid_o,
   output logic                pcis_wvalid_o,
   input  logic                pcis_wready_i,
   output shell_pkg::beat_t    pcis_wdata_o,
   output shell_pkg::strb_t    pcis_wstrb_o,
   input  logic                pcis_bvalid_i,
   output logic                pcis_bready_o,
   input  shell_pkg::axi_id_t  pcis_bid_i,
   input  shell_pkg::resp_t    pcis_bresp_i
);

   shell_pkg::wr_state_t state_q;
   shell_pkg::addr_t     addr_q;
   shell_pkg::word_t     wdata_q;
   shell_pkg::axi_id_t   id_q;
   shell_pkg::axi_id_t   bid_q;
   shell_pkg::resp_t     bresp_q;
   logic                 rsp_valid_q;
   logic [shell_pkg::LANE_MSB-shell_pkg::LANE_LSB:0] lane;

   assign lane      = addr_q[shell_pkg::LANE_MSB:shell_pkg::LANE_LSB];
   assign req.ready = (state_q == shell_pkg::W_IDLE);

   assign pcis_awaddr_o = addr_q;
   assign pcis_awid_o   = id_q;
   // word into lane, four strobes for its bytes
   assign pcis_wdata_o  = shell_pkg::beat_t'(wdata_q) << {lane, 5'd0};
   assign pcis_wstrb_o  = shell_pkg::strb_t'(4'hf) << {lane, 2'd0};

   assign rsp.valid = rsp_valid_q;
   assign rsp.id    = bid_q;
   assign rsp.resp  = bresp_q;
   assign rsp.rdata = '0;

   always_ff @(posedge clk_out) begin
      if (req.valid && req.ready) begin
         addr_q  <= req.addr;
         wdata_q <= req.wdata;
         id_q    <= req.id;
      end
      if (pcis_bvalid_i && pcis_bready_o) begin
         bid_q   <= pcis_bid_i;
         bresp_q <= pcis_bresp_i;
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q        <= shell_pkg::W_IDLE;
         pcis_awvalid_o <= 1'b0;
         pcis_wvalid_o  <= 1'b0;
         pcis_bready_o  <= 1'b0;
         rsp_valid_q    <= 1'b0;
      end else begin
         case (state_q)
            shell_pkg::W_IDLE: begin
               if (req.valid) begin
                  pcis_awvalid_o <= 1'b1;
                  pcis_wvalid_o  <= 1'b1;
                  state_q        <= shell_pkg::W_ADDR_DATA;
               end
            end
            shell_pkg::W_ADDR_DATA: begin
               // aw and w finish independently
               if (pcis_awready_i)
                  pcis_awvalid_o <= 1'b0;
               if (pcis_wready_i)
                  pcis_wvalid_o <= 1'b0;
               if ((!pcis_awvalid_o || pcis_awready_i) && (!pcis_wvalid_o || pcis_wready_i)) begin
                  pcis_bready_o <= 1'b1;
                  state_q       <= shell_pkg::W_RESP;
               end
            end
            shell_pkg::W_RESP: begin
               if (pcis_bready_o && pcis_bvalid_i) begin
                  pcis_bready_o <= 1'b0;
                  rsp_valid_q   <= 1'b1;
               end else if (rsp_valid_q && rsp.ready) begin
                  rsp_valid_q <= 1'b0;
                  state_q     <= shell_pkg::W_IDLE;
               end
            end
            default: state_q <= shell_pkg::W_IDLE;
         endcase
      end
   end

   a_bid_match: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      (pcis_bvalid_i && pcis_bready_o) |-> (pcis_bid_i == id_q));

endmodule

// ==== design/pcis_read_master.sv ====
/*
 * Single-beat AXI4 read engine on pcis. Issues AR for one peek and pulls
 * the addressed word out of the returned beat for the host response.
 */

`timescale 1ns/1ps

module pcis_read_master (
   input  logic                clk_out,
   input  logic                sync_rst_n,
   host_req_if.dst             req,
   host_rsp_if.src             rsp,
   output logic                pcis_arvalid_o,
   input  logic                pcis_arready_i,
   output shell_pkg::addr_t    pcis_araddr_o,
   output shell_pkg::axi_id_t  pcis_arid_o,
   input  logic                pcis_rvalid_i,
   output logic                pcis_rready_o,
   input  shell_pkg::axi_id_t  pcis_rid_i,
   input  shell_pkg::beat_t    pcis_rdata_i,
   input  shell_pkg::resp_t    pcis_rresp_i
);

   shell_pkg::rd_state_t state_q;
   shell_pkg::addr_t     addr_q;
   shell_pkg::axi_id_t   id_q;
   shell_pkg::axi_id_t   rid_q;
   shell_pkg::word_t     rdata_q;
   shell_pkg::resp_t     rresp_q;
   logic                 rsp_valid_q;
   logic [shell_pkg::LANE_MSB-shell_pkg::LANE_LSB:0] lane;

   assign lane          = addr_q[shell_pkg::LANE_MSB:shell_pkg::LANE_LSB];
   assign req.ready     = (state_q == shell_pkg::R_IDLE);
   assign pcis_araddr_o = addr_q;
   assign pcis_arid_o   = id_q;

   assign rsp.valid = rsp_valid_q;
   assign rsp.id    = rid_q;
   assign rsp.rdata = rdata_q;
   assign rsp.resp  = rresp_q;

   always_ff @(posedge clk_out) begin
      if (req.valid && req.ready) begin
         addr_q <= req.addr;
         id_q   <= req.id;
      end
      if (pcis_rvalid_i && pcis_rready_o) begin
         rid_q   <= pcis_rid_i;
         rresp_q <= pcis_rresp_i;
         rdata_q <= pcis_rdata_i[{lane, 5'd0} +: 32];
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q        <= shell_pkg::R_IDLE;
         pcis_arvalid_o <= 1'b0;
         pcis_rready_o  <= 1'b0;
         rsp_valid_q    <= 1'b0;
      end else begin
         case (state_q)
            shell_pkg::R_IDLE: begin
               if (req.valid) begin
                  pcis_arvalid_o <= 1'b1;
                  state_q        <= shell_pkg::R_ADDR;
               end
            end
            shell_pkg::R_ADDR: begin
               if (pcis_arready_i) begin
                  pcis_arvalid_o <= 1'b0;
                  pcis_rready_o  <= 1'b1;
                  state_q        <= shell_pkg::R_DATA;
               end
            end
            shell_pkg::R_DATA: begin
               if (pcis_rvalid_i) begin
                  pcis_rready_o <= 1'b0;
                  rsp_valid_q   <= 1'b1;
                  state_q       <= shell_pkg::R_RESP;
               end
            end
            default: begin
               // R_RESP, hold until merge takes it
               if (rsp.ready) begin
                  rsp_valid_q <= 1'b0;
                  state_q     <= shell_pkg::R_IDLE;
               end
            end
         endcase
      end
   end

   a_ar_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      (pcis_arvalid_o && !pcis_arready_i) |=> pcis_arvalid_o);

endmodule

// ==== design/host_rsp_merge.sv ====
/*
 * Joins write and read engine responses into one registered host response.
 * Write wins a tie; the output register holds under host back-pressure.
 */

`timescale 1ns/1ps

module host_rsp_merge (
   input  logic                clk_out,
   input  logic                sync_rst_n,
   host_rsp_if.dst             wr_rsp,
   host_rsp_if.dst             rd_rsp,
   output logic                rsp_valid_o,
   input  logic                rsp_ready_i,
   output shell_pkg::axi_id_t  rsp_id_o,
   output shell_pkg::word_t    rsp_rdata_o,
   output shell_pkg::resp_t    rsp_resp_o
);

   logic load_ok;
   logic take_wr;
   logic take_rd;

   // register free or draining this cycle
   assign load_ok      = !rsp_valid_o || rsp_ready_i;
   assign wr_rsp.ready = load_ok;
   assign rd_rsp.ready = load_ok && !wr_rsp.valid;
   assign take_wr      = wr_rsp.valid && wr_rsp.ready;
   assign take_rd      = rd_rsp.valid && rd_rsp.ready;

   always_ff @(posedge clk_out) begin
      if (take_wr) begin
         rsp_id_o    <= wr_rsp.id;
         rsp_rdata_o <= wr_rsp.rdata;
         rsp_resp_o  <= wr_rsp.resp;
      end else if (take_rd) begin
         rsp_id_o    <= rd_rsp.id;
         rsp_rdata_o <= rd_rsp.rdata;
         rsp_resp_o  <= rd_rsp.resp;
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n)
         rsp_valid_o <= 1'b0;
      else if (take_wr || take_rd)
         rsp_valid_o <= 1'b1;
      else if (rsp_ready_i)
         rsp_valid_o <= 1'b0;
   end

endmodule

// ==== design/sh_pcis_shell.sv ====
/*
 * Top level of the host-side pcis master: request queue, write and read
 * engines and response merge. Host side valid/ready, CL side AXI4 single beats.
 */

`timescale 1ns/1ps

module sh_pcis_shell #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic               clk_out,
   input  logic               sync_rst_n,
   input  logic               flr_i,
   // host requests
   input  logic               req_valid_i,
   input  logic               req_write_i,
   input  shell_pkg::addr_t   req_addr_i,
   input  shell_pkg::word_t   req_wdata_i,
   input  shell_pkg::axi_id_t req_id_i,
   output logic               req_ready_o,
   // host responses
   output logic               rsp_valid_o,
   output shell_pkg::axi_id_t rsp_id_o,
   output shell_pkg::word_t   rsp_rdata_o,
   output shell_pkg::resp_t   rsp_resp_o,
   input  logic               rsp_ready_i,
   // ----------------------------------------
   // pcis AXI4 toward CL
   // ----------------------------------------
   output logic               pcis_awvalid_o,
   output shell_pkg::addr_t   pcis_awaddr_o,
   output shell_pkg::axi_id_t pcis_awid_o,
   input  logic               pcis_awready_i,
   output logic               pcis_wvalid_o,
   output shell_pkg::beat_t   pcis_wdata_o,
   output shell_pkg::strb_t   pcis_wstrb_o,
   input  logic               pcis_wready_i,
   input  logic               pcis_bvalid_i,
   input  shell_pkg::axi_id_t pcis_bid_i,
   input  shell_pkg::resp_t   pcis_bresp_i,
   output logic               pcis_bready_o,
   output logic               pcis_arvalid_o,
   output shell_pkg::addr_t   pcis_araddr_o,
   output shell_pkg::axi_id_t pcis_arid_o,
   input  logic               pcis_arready_i,
   input  logic               pcis_rvalid_i,
   input  shell_pkg::axi_id_t pcis_rid_i,
   input  shell_pkg::beat_t   pcis_rdata_i,
   input  shell_pkg::resp_t   pcis_rresp_i,
   output logic               pcis_rready_o
);

   host_req_if wr_req_if ();
   host_req_if rd_req_if ();
   host_rsp_if wr_rsp_if ();
   host_rsp_if rd_rsp_if ();

   host_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_host_req_fifo (
      .clk_out, .sync_rst_n, .flr_i,
      .req_valid_i, .req_write_i, .req_addr_i, .req_wdata_i, .req_id_i, .req_ready_o,
      .wr_req (wr_req_if.src),
      .rd_req (rd_req_if.src)
   );

   pcis_write_master i_pcis_write_master (
      .clk_out, .sync_rst_n,
      .req (wr_req_if.dst),
      .rsp (wr_rsp_if.src),
      .pcis_awvalid_o, .pcis_awready_i, .pcis_awaddr_o, .pcis_awid_o,
      .pcis_wvalid_o, .pcis_wready_i, .pcis_wdata_o, .pcis_wstrb_o,
      .pcis_bvalid_i, .pcis_bready_o, .pcis_bid_i, .pcis_bresp_i
   );

   pcis_read_master i_pcis_read_master (
      .clk_out, .sync_rst_n,
      .req (rd_req_if.dst),
      .rsp (rd_rsp_if.src),
      .pcis_arvalid_o, .pcis_arready_i, .pcis_araddr_o, .pcis_arid_o,
      .pcis_rvalid_i, .pcis_rready_o, .pcis_rid_i, .pcis_rdata_i, .pcis_rresp_i
   );

   host_rsp_merge i_host_rsp_merge (
      .clk_out, .sync_rst_n,
      .wr_rsp (wr_rsp_if.dst),
      .rd_rsp (rd_rsp_if.dst),
      .rsp_valid_o, .rsp_ready_i, .rsp_id_o, .rsp_rdata_o, .rsp_resp_o
   );

endmodule

// ==== testbench/cl_mem_model.sv ====
/*
 * Custom-logic AXI4 slave memory for the pcis testbench. 4 KiB of words,
 * single-beat transfers, SLVERR above the limit, readies drop at random.
 */

`timescale 1ns/1ps

module cl_mem_model #(
   parameter logic [15:0] SEED = 16'd39399
) (
   input  logic               clk_out,
   input  logic               sync_rst_n,
   input  logic               awvalid_i,
   input  shell_pkg::addr_t   awaddr_i,
   input  shell_pkg::axi_id_t awid_i,
   output logic               awready_o,
   input  logic               wvalid_i,
   input  shell_pkg::beat_t   wdata_i,
   input  shell_pkg::strb_t   wstrb_i,
   output logic               wready_o,
   output logic               bvalid_o,
   output shell_pkg::axi_id_t bid_o,
   output shell_pkg::resp_t   bresp_o,
   input  logic               bready_i,
   input  logic               arvalid_i,
   input  shell_pkg::addr_t   araddr_i,
   input  shell_pkg::axi_id_t arid_i,
   output logic               arready_o,
   output logic               rvalid_o,
   output shell_pkg::axi_id_t rid_o,
   output shell_pkg::beat_t   rdata_o,
   output shell_pkg::resp_t   rresp_o,
   input  logic               rready_i
);

   shell_pkg::word_t   mem [1024];
   logic               aw_got;
   logic               w_got;
   shell_pkg::addr_t   aw_addr;
   shell_pkg::axi_id_t aw_id;
   shell_pkg::beat_t   w_data;
   shell_pkg::strb_t   w_strb;
   logic [15:0]        lfsr_q;
   logic [15:0]        lfsr_1;
   logic [15:0]        lfsr_2;
   logic [15:0]        lfsr_3;
   logic               aw_rdy_q;
   logic               w_rdy_q;
   logic               ar_rdy_q;
   logic               do_write;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   function automatic shell_pkg::beat_t line_beat(input logic [5:0] line);
      shell_pkg::beat_t b;
      for (int i = 0; i < 16; i++)
         b[i*32 +: 32] = mem[{line, i[3:0]}];
      return b;
   endfunction

   // fill pattern from the word index
   initial begin
      for (int i = 0; i < 1024; i++)
         mem[i] = 32'hc3000000 | (i << 12) | i;
   end

   assign lfsr_1    = lfsr_step(lfsr_q);
   assign lfsr_2    = lfsr_step(lfsr_1);
   assign lfsr_3    = lfsr_step(lfsr_2);
   assign awready_o = aw_rdy_q && !aw_got;
   assign wready_o  = w_rdy_q && !w_got;
   assign arready_o = ar_rdy_q && !rvalid_o;
   assign do_write  = aw_got && w_got && !bvalid_o;

   always @(posedge clk_out) begin
      if (do_write && aw_addr < 64'h1000) begin
         for (int i = 0; i < 64; i++) begin
            if (w_strb[i])
               mem[{aw_addr[11:6], i[5:2]}][i[1:0]*8 +: 8] <= w_data[i*8 +: 8];
         end
      end
   end

   always @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         lfsr_q   <= SEED;
         aw_rdy_q <= 1'b0;
         w_rdy_q  <= 1'b0;
         ar_rdy_q <= 1'b0;
         aw_got   <= 1'b0;
         w_got    <= 1'b0;
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         lfsr_q   <= lfsr_3;
         aw_rdy_q <= lfsr_q[0];
         w_rdy_q  <= lfsr_1[0];
         ar_rdy_q <= lfsr_2[0];
         if (awvalid_i && awready_o) begin
            aw_got  <= 1'b1;
            aw_addr <= awaddr_i;
            aw_id   <= awid_i;
         end
         if (wvalid_i && wready_o) begin
            w_got  <= 1'b1;
            w_data <= wdata_i;
            w_strb <= wstrb_i;
         end
         if (do_write) begin
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bvalid_o <= 1'b1;
            bid_o    <= aw_id;
            bresp_o  <= (aw_addr < 64'h1000) ? shell_pkg::RESP_OKAY : shell_pkg::RESP_SLVERR;
         end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
         if (arvalid_i && arready_o) begin
            rvalid_o <= 1'b1;
            rid_o    <= arid_i;
            if (araddr_i < 64'h1000) begin
               rdata_o <= line_beat(araddr_i[11:6]);
               rresp_o <= shell_pkg::RESP_OKAY;
            end else begin
               rdata_o <= '0;
               rresp_o <= shell_pkg::RESP_SLVERR;
            end
         end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
         end
      end
   end

endmodule

// ==== testbench/tb_sh_pcis_shell.sv ====
/*
 * Testbench for sh_pcis_shell. Posts pokes and peeks, predicts each response
 * from a shadow memory and checks it by id when the host response arrives.
 */

`timescale 1ns/1ps

module tb_sh_pcis_shell;

   localparam int  TOTAL_REQ  = 300;
   localparam real CLK_PERIOD = 8.0;

   logic               clk_out = 1'b0;
   logic               sync_rst_n;
   logic               flr_i;
   logic               req_valid_i;
   logic               req_write_i;
   shell_pkg::addr_t   req_addr_i;
   shell_pkg::word_t   req_wdata_i;
   shell_pkg::axi_id_t req_id_i;
   logic               req_ready_o;
   logic               rsp_valid_o;
   shell_pkg::axi_id_t rsp_id_o;
   shell_pkg::word_t   rsp_rdata_o;
   shell_pkg::resp_t   rsp_resp_o;
   logic               rsp_ready_i = 1'b0;
   logic               pcis_awvalid_o;
   shell_pkg::addr_t   pcis_awaddr_o;
   shell_pkg::axi_id_t pcis_awid_o;
   logic               pcis_awready_i;
   logic               pcis_wvalid_o;
   shell_pkg::beat_t   pcis_wdata_o;
   shell_pkg::strb_t   pcis_wstrb_o;
   logic               pcis_wready_i;
   logic               pcis_bvalid_i;
   shell_pkg::axi_id_t pcis_bid_i;
   shell_pkg::resp_t   pcis_bresp_i;
   logic               pcis_bready_o;
   logic               pcis_arvalid_o;
   shell_pkg::addr_t   pcis_araddr_o;
   shell_pkg::axi_id_t pcis_arid_o;
   logic               pcis_arready_i;
   logic               pcis_rvalid_i;
   shell_pkg::axi_id_t pcis_rid_i;
   shell_pkg::beat_t   pcis_rdata_i;
   shell_pkg::resp_t   pcis_rresp_i;
   logic               pcis_rready_o;

   // expectations per id, filled when a request is posted
   shell_pkg::word_t   shadow [1024];
   logic               pend_q [64];
   shell_pkg::resp_t   exp_resp [64];
   shell_pkg::word_t   exp_rdata [64];
   int                 exp_line [64];
   int                 rd_line_cnt [64];
   int                 in_flight = 0;
   int                 answered = 0;
   int                 checks = 0;
   int                 errors = 0;
   int                 err_mark = 0;
   logic [15:0]        lfsr_main = 16'd39399;
   logic [15:0]        lfsr_gap = 16'd39399;
   logic               hold_rsp = 1'b1;
   logic [31:0]        gap;

   sh_pcis_shell #(.FIFO_DEPTH(4)) i_sh_pcis_shell (.*);

   cl_mem_model i_cl_mem_model (
      .clk_out, .sync_rst_n,
      .awvalid_i (pcis_awvalid_o), .awaddr_i (pcis_awaddr_o), .awid_i (pcis_awid_o),
      .awready_o (pcis_awready_i),
      .wvalid_i (pcis_wvalid_o), .wdata_i (pcis_wdata_o), .wstrb_i (pcis_wstrb_o),
      .wready_o (pcis_wready_i),
      .bvalid_o (pcis_bvalid_i), .bid_o (pcis_bid_i), .bresp_o (pcis_bresp_i),
      .bready_i (pcis_bready_o),
      .arvalid_i (pcis_arvalid_o), .araddr_i (pcis_araddr_o), .arid_i (pcis_arid_o),
      .arready_o (pcis_arready_i),
      .rvalid_o (pcis_rvalid_i), .rid_o (pcis_rid_i), .rdata_o (pcis_rdata_i),
      .rresp_o (pcis_rresp_i), .rready_i (pcis_rready_o)
   );

   always #(CLK_PERIOD / 2.0) clk_out = ~clk_out;

   // galois lfsr, one step per bit; gap stream kept apart from stimulus
   function automatic logic [31:0] rand_bits(input int n, input logic gap_stream);
      logic [31:0] v;
      logic [15:0] s;
      v = '0;
      s = gap_stream ? lfsr_gap : lfsr_main;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], s[0]};
         s = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
      end
      if (gap_stream)
         lfsr_gap = s;
      else
         lfsr_main = s;
      return v;
   endfunction

   // expected response by the shell rules, shadow updated in request order
   function automatic void ref_model(input logic write, input shell_pkg::addr_t a,
                                     input shell_pkg::word_t d,
                                     output shell_pkg::resp_t r, output shell_pkg::word_t q);
      if (a >= 64'h1000) begin
         r = shell_pkg::RESP_SLVERR;
         q = '0;
      end else if (write) begin
         shadow[a[11:2]] = d;
         r = shell_pkg::RESP_OKAY;
         q = '0;
      end else begin
         r = shell_pkg::RESP_OKAY;
         q = shadow[a[11:2]];
      end
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // called at a falling edge, returns at the falling edge after the handshake
   task automatic send_req(input logic write, input shell_pkg::addr_t a,
                           input shell_pkg::word_t d, output shell_pkg::axi_id_t id);
      shell_pkg::resp_t r;
      shell_pkg::word_t q;
      logic             took;
      // random id, never one still in flight
      do begin
         id = shell_pkg::axi_id_t'(rand_bits(6, 1'b0));
      end while (pend_q[id]);
      ref_model(write, a, d, r, q);
      exp_resp[id]  = r;
      exp_rdata[id] = q;
      exp_line[id]  = (!write && a < 64'h1000) ? int'(a[11:6]) : -1;
      if (exp_line[id] >= 0)
         rd_line_cnt[exp_line[id]]++;
      pend_q[id] = 1'b1;
      in_flight++;
      req_valid_i = 1'b1;
      req_write_i = write;
      req_addr_i  = a;
      req_wdata_i = d;
      req_id_i    = id;
      do begin
         took = req_ready_o;
         @(negedge clk_out);
      end while (!took);
      req_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      while (in_flight != 0)
         @(negedge clk_out);
   endtask

   task automatic finish_test(input string name);
      $display("test %s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   always @(negedge clk_out) begin
      gap = rand_bits(2, 1'b1);
      rsp_ready_i <= hold_rsp ? 1'b0 : (gap[1:0] != 2'b00);
   end

   // ----------------------------------------
   // response checker
   // ----------------------------------------
   always @(posedge clk_out) begin
      if (sync_rst_n && rsp_valid_o && rsp_ready_i) begin
         if (!pend_q[rsp_id_o]) begin
            errors++;
            $display("response for id %0d which is not in flight", rsp_id_o);
         end else begin
            check_val("rsp_resp_o", 64'(rsp_resp_o), 64'(exp_resp[rsp_id_o]));
            check_val("rsp_rdata_o", 64'(rsp_rdata_o), 64'(exp_rdata[rsp_id_o]));
            if (exp_line[rsp_id_o] >= 0)
               rd_line_cnt[exp_line[rsp_id_o]]--;
            pend_q[rsp_id_o] = 1'b0;
            in_flight--;
            answered++;
         end
      end
   end

   initial begin
      #(TOTAL_REQ * 200 * CLK_PERIOD);
      $display("watchdog timeout, requests still outstanding: %0d", in_flight);
      $display("RESULT: FAIL");
      $finish;
   end

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial begin
      shell_pkg::axi_id_t id;
      shell_pkg::addr_t   a;
      shell_pkg::addr_t   last_wr;
      shell_pkg::word_t   d;
      logic [31:0]        r;
      logic [31:0]        t;
      logic               write;
      logic               have_wr;
      int                 mark;
      int                 quiet;
      int                 fl_n;
      shell_pkg::axi_id_t fl_id [10];
      shell_pkg::addr_t   fl_addr [10];
      shell_pkg::word_t   fl_old [10];

      sync_rst_n  = 1'b0;
      flr_i       = 1'b0;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_id_i    = '0;
      have_wr     = 1'b0;
      last_wr     = '0;
      for (int i = 0; i < 1024; i++)
         shadow[i] = 32'hc3000000 | (i << 12) | i;
      for (int i = 0; i < 64; i++) begin
         pend_q[i]      = 1'b0;
         rd_line_cnt[i] = 0;
      end
      repeat (3) @(posedge clk_out);
      @(negedge clk_out);
      sync_rst_n = 1'b1;
      hold_rsp   <= 1'b0;

      // every lane of one line
      for (int lane = 0; lane < 16; lane++) begin
         a = 64'h140 | 64'(lane * 4);
         d = rand_bits(32, 1'b0);
         send_req(1'b1, a, d, id);
         send_req(1'b0, a, 32'h0, id);
      end
      wait_idle();
      finish_test("lane poke/peek");

      // random mix, peeks often chase the last poke
      for (int n = 0; n < 200; n++) begin
         r = rand_bits(4, 1'b0);
         if (have_wr && r[0]) begin
            write = 1'b0;
            t = rand_bits(4, 1'b0);
            a = {last_wr[63:6], t[3:0], 2'b00};
         end else begin
            write = r[1];
            t = rand_bits(10, 1'b0);
            a = {52'd0, t[9:0], 2'b00};
            if (r[1] && r[2] && r[3])
               a = a | 64'h1000;
            // no poke into a line with a peek still pending
            if (write && a < 64'h1000 && rd_line_cnt[a[11:6]] != 0)
               write = 1'b0;
         end
         d = rand_bits(32, 1'b0);
         if (write) begin
            have_wr = 1'b1;
            last_wr = a;
         end
         send_req(write, a, d, id);
      end
      wait_idle();
      finish_test("random interleave");

      for (int n = 0; n < 8; n++) begin
         t = rand_bits(20, 1'b0);
         a = {44'd0, t[19:2], 2'b00} | 64'h1000;
         d = rand_bits(32, 1'b0);
         send_req(1'b1, a, d, id);
         send_req(1'b0, a, 32'h0, id);
      end
      wait_idle();
      finish_test("slverr range");

      // host back-pressure
      hold_rsp <= 1'b1;
      mark = answered;
      fl_n = 0;
      while (req_ready_o && fl_n < 10) begin
         send_req(1'b1, 64'hd00 | 64'(fl_n * 4), rand_bits(32, 1'b0), id);
         fl_n++;
      end
      if (req_ready_o) begin
         errors++;
         $display("req_ready_o stayed high with responses held back");
      end
      hold_rsp <= 1'b0;
      wait_idle();
      if (answered - mark != fl_n) begin
         errors++;
         $display("posted %0d requests but %0d were answered", fl_n, answered - mark);
      end
      finish_test("backpressure");

      // flr with queued pokes
      hold_rsp <= 1'b1;
      mark = answered;
      fl_n = 0;
      while (req_ready_o && fl_n < 10) begin
         fl_addr[fl_n] = 64'he00 | 64'(fl_n * 4);
         fl_old[fl_n]  = shadow[fl_addr[fl_n][11:2]];
         send_req(1'b1, fl_addr[fl_n], rand_bits(32, 1'b0), id);
         fl_id[fl_n] = id;
         fl_n++;
      end
      flr_i = 1'b1;
      repeat (2) @(negedge clk_out);
      flr_i    = 1'b0;
      hold_rsp <= 1'b0;
      quiet = 0;
      while (quiet < 8) begin
         @(negedge clk_out);
         if (rsp_valid_o || pcis_awvalid_o || pcis_wvalid_o || pcis_bready_o
             || pcis_arvalid_o || pcis_rready_o)
            quiet = 0;
         else
            quiet++;
      end
      if (answered - mark > 2) begin
         errors++;
         $display("flush let %0d requests through", answered - mark);
      end
      // flushed pokes never reached memory
      for (int i = 0; i < fl_n; i++) begin
         if (pend_q[fl_id[i]]) begin
            pend_q[fl_id[i]] = 1'b0;
            in_flight--;
            shadow[fl_addr[i][11:2]] = fl_old[i];
         end
      end
      for (int i = 0; i < fl_n; i++)
         send_req(1'b0, fl_addr[i], 32'h0, id);
      wait_idle();
      finish_test("flr flush");

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== project.f ====
design/shell_pkg.sv
design/shell_if.sv
design/host_req_fifo.sv
design/pcis_write_master.sv
design/pcis_read_master.sv
design/host_rsp_merge.sv
design/sh_pcis_shell.sv
testbench/cl_mem_model.sv
testbench/tb_sh_pcis_shell.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_sh_pcis_shell -f project.f

sim:
	verilator --binary --timing --assert --top-module tb_sh_pcis_shell -f project.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	! grep -q "RESULT: FAIL" $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
